// File: rtl/ql_bus_pkg.sv
package ql_bus_pkg;

	//==========================================================================
	// Bus types
	//==========================================================================

	// 68008 request, strobes already active high
	typedef struct packed {
		logic [23:0] addr; // Byte address
		logic        as;   // Address strobe
		logic        rw;   // 1 = read
		logic        uds;  // Upper byte strobe
		logic        lds;  // Lower byte strobe
		logic [15:0] dout; // Write data from CPU
	} cpu_bus_t;

	// One flag per decoded region
	typedef struct packed {
		logic rom;         // 000000..00ffff
		logic ext_rom;     // 00c000..00ffff
		logic os_rom;      // ROM minus ext ROM
		logic ql_io;       // 018000..01bfff
		logic ram;         // Any RAM
		logic gc_io;       // 01c000..01c0ff, GoldCard only
		logic gc_boot_rom; // 040000..04ffff
		logic gc_os_rom;   // 400000..40ffff
		logic rd;          // Read cycle
		logic wr;          // Write cycle
	} region_t;

	typedef enum logic [1:0] {RAM_128K, RAM_640K, RAM_896K, RAM_4096K} ram_cfg_e;
	typedef enum logic [1:0] {SPEED_QL, SPEED_16, SPEED_24, SPEED_FULL} cpu_speed_e;

	//==========================================================================
	// Constants
	//==========================================================================

	// Phase increments for 84 MHz over 2^16
	localparam logic [16:0] FRACT_BUS_QL   = 17'd11702; // ~15 MHz
	localparam logic [16:0] FRACT_BUS_16   = 17'd24966; // ~32 MHz
	localparam logic [16:0] FRACT_BUS_24   = 17'd37449; // ~48 MHz
	localparam logic [16:0] FRACT_BUS_FULL = 17'd65536; // Every cycle
	localparam logic [16:0] FRACT_SD       = 17'd19505;
	localparam logic [16:0] FRACT_11M      = 17'd8582;  // IPC clock

	// Address wrap per RAM size
	localparam logic [23:0] MASK_128K = 24'h03FFFF;
	localparam logic [23:0] MASK_1M   = 24'h0FFFFF;
	localparam logic [23:0] MASK_8M   = 24'h7FFFFF;

	localparam logic [7:0]  GC_SHADOW_ON  = 8'h60; // Offsets inside gc_io
	localparam logic [7:0]  GC_SHADOW_OFF = 8'h64;
	localparam logic [23:0] MC_STAT_ADDR  = 24'h018063; // ZX8301 mode register

	localparam logic [15:0] UNMAPPED_DATA = 16'hFFFF; // Open bus

	localparam logic [7:0] REG_CTRL   = 8'h00; // APB register map
	localparam logic [7:0] REG_STATUS = 8'h04;

endpackage

// File: rtl/ql_cfg_apb.sv
`timescale 1ns/1ps

module ql_cfg_apb
#(
	parameter int RESET_TICKS = 4095
)
(
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic [7:0]             paddr,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [31:0]            pwdata,
	output logic [31:0]            prdata,
	output logic                   pready,
	output logic                   pslverr,
	input  logic                   ce_bus_p,
	input  logic                   rom_shadow,
	input  logic [7:0]             mc_stat,
	output ql_bus_pkg::cpu_speed_e cpu_speed,
	output ql_bus_pkg::ram_cfg_e   eff_ram_cfg,
	output logic                   core_reset
);
	import ql_bus_pkg::*;

	localparam int CNT_W = $clog2(RESET_TICKS + 1);

	// Control register, packed to match REG_CTRL bits 4:0
	typedef struct packed {
		logic       soft_reset;
		ram_cfg_e   ram_cfg;
		cpu_speed_e cpu_speed;
	} ctrl_t;

	ctrl_t            ctrl;
	logic [CNT_W-1:0] reset_cnt; // Bus ticks left in reset stretch
	logic             apb_acc;
	logic             addr_ok;

	assign apb_acc = psel && penable; // Access phase
	assign addr_ok = (paddr == REG_CTRL) || (paddr == REG_STATUS);
	assign pready  = 1'b1;            // Never waits
	assign pslverr = apb_acc && !addr_ok;

	always_comb
	begin
		case (paddr)
			REG_CTRL:   prdata = {27'd0, ctrl};
			REG_STATUS: prdata = {16'd0, mc_stat, 4'd0, core_reset, rom_shadow, eff_ram_cfg};
			default:    prdata = 32'd0; // Unknown offsets read as zero
		endcase
	end

	always_ff @(posedge clk_sys)
	begin
		if (reset)
			ctrl <= '{soft_reset: 1'b0, ram_cfg: RAM_128K, cpu_speed: SPEED_QL};
		else if (apb_acc && pwrite && paddr == REG_CTRL)
			ctrl <= ctrl_t'(pwdata[4:0]);
	end

	// Reset stretch, counts down on CPU bus ticks
	always_ff @(posedge clk_sys)
	begin
		if (reset || ctrl.soft_reset)
			reset_cnt <= CNT_W'(RESET_TICKS);
		else if (ce_bus_p && reset_cnt != '0)
			reset_cnt <= reset_cnt - 1'b1;
	end

	assign core_reset = reset || ctrl.soft_reset || (reset_cnt != '0);

	// RAM size only changes while the core sits in reset
	always_ff @(posedge clk_sys)
	begin
		if (core_reset)
			eff_ram_cfg <= ctrl.ram_cfg;
	end

	assign cpu_speed = ctrl.cpu_speed;

	// Rejected writes must not disturb the register
	err_wr_ignored: assert property (@(posedge clk_sys) disable iff (reset)
		(apb_acc && pwrite && pslverr) |=> $stable(ctrl));

endmodule

// File: rtl/ql_ce_gen.sv
`timescale 1ns/1ps

module ql_ce_gen
(
	input  logic                   clk_sys,
	input  logic                   reset,
	input  ql_bus_pkg::cpu_speed_e cpu_speed,
	output logic                   ce_bus_p,
	output logic                   ce_bus_n,
	output logic                   ce_sd,
	output logic                   ce_11m
);
	import ql_bus_pkg::*;

	logic [2:0][16:0] incr; // 0 = bus, 1 = SD, 2 = IPC
	wire  [2:0]       tick; // Registered carry per channel
	logic             bus_pol;

	always_comb
	begin
		case (cpu_speed)
			SPEED_QL: incr[0] = FRACT_BUS_QL;
			SPEED_16: incr[0] = FRACT_BUS_16;
			SPEED_24: incr[0] = FRACT_BUS_24;
			default:  incr[0] = FRACT_BUS_FULL; // Full speed, tick every cycle
		endcase
		incr[1] = FRACT_SD;
		incr[2] = FRACT_11M;
	end

	//==========================================================================
	// Phase accumulators
	//==========================================================================
	for (genvar i = 0; i < 3; i++)
	begin : g_chan
		logic [15:0] acc;
		logic        carry;

		always_ff @(posedge clk_sys)
		begin
			if (reset)
			begin
				acc   <= '0;
				carry <= 1'b0;
			end
			else
				{carry, acc} <= {1'b0, acc} + incr[i]; // Carry out is the enable
		end

		assign tick[i] = carry;
	end

	// Alternate bus ticks between the two CPU phases
	always_ff @(posedge clk_sys)
	begin
		if (reset)
			bus_pol <= 1'b0; // First tick lands on phase p
		else if (tick[0])
			bus_pol <= !bus_pol;
	end

	assign ce_bus_p = tick[0] && !bus_pol;
	assign ce_bus_n = tick[0] && bus_pol;
	assign ce_sd    = tick[1];
	assign ce_11m   = tick[2];

	bus_phase_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(ce_bus_p && ce_bus_n));

endmodule

// File: rtl/ql_addr_decode.sv
`timescale 1ns/1ps

module ql_addr_decode
(
	input  ql_bus_pkg::cpu_bus_t cpu_bus,
	input  ql_bus_pkg::ram_cfg_e eff_ram_cfg,
	output logic [23:0]          addr,
	output ql_bus_pkg::region_t  region
);
	import ql_bus_pkg::*;

	logic [23:0] mask;
	logic        gc_en;   // GoldCard memory map
	logic        strobe;
	logic        bram;    // Base 128k
	logic        xram;    // Extended RAM above 040000
	logic        gc_io;
	logic        gc_ram1; // 010000..017fff
	logic        gc_ram2; // 01c100..01ffff

	//==========================================================================
	// Address wrap
	//==========================================================================
	always_comb
	begin
		case (eff_ram_cfg)
			RAM_128K:           mask = MASK_128K; // Wraps at 256k
			RAM_640K, RAM_896K: mask = MASK_1M;
			default:            mask = MASK_8M;   // 4M RAM plus GoldCard space
		endcase
	end

	assign addr   = cpu_bus.addr & mask;
	assign gc_en  = (eff_ram_cfg == RAM_4096K);
	assign strobe = cpu_bus.uds || cpu_bus.lds;

	//==========================================================================
	// RAM regions
	//==========================================================================
	assign bram = (addr[23:17] == 7'h01); // 020000..03ffff

	always_comb
	begin
		case (eff_ram_cfg)
			RAM_640K:  xram = (addr[23:20] == 4'h0) && ^addr[19:18]; // ..0bffff
			RAM_896K:  xram = (addr[23:20] == 4'h0) && |addr[19:18]; // ..0fffff
			RAM_4096K: xram = (addr[23:22] == 2'b00) && |addr[21:18]; // ..3fffff
			default:   xram = 1'b0;
		endcase
	end

	assign gc_io   = gc_en && (addr[23:8] == 16'h01C0);
	assign gc_ram1 = gc_en && (addr[23:15] == 9'h002);
	assign gc_ram2 = gc_en && (addr[23:14] == 10'h007) && !gc_io; // Above the I/O page

	always_comb
	begin
		region.rom         = (addr[23:16] == 8'h00);
		region.ext_rom     = (addr[23:14] == 10'h003);
		region.os_rom      = region.rom && !region.ext_rom;
		region.ql_io       = (addr[23:14] == 10'h006); // Always mapped
		region.ram         = bram || xram || gc_ram1 || gc_ram2;
		region.gc_io       = gc_io;
		region.gc_boot_rom = gc_en && (addr[23:16] == 8'h04); // Boot ROM mirror
		region.gc_os_rom   = gc_en && (addr[23:16] == 8'h40); // QL ROM mirror
		region.rd          = cpu_bus.as && cpu_bus.rw && strobe;
		region.wr          = cpu_bus.as && !cpu_bus.rw && strobe;
	end

	// ROM window must stay clear of every RAM range, in every config
	ram_rom_excl: assert final (!(region.ram && region.rom));

endmodule

// File: rtl/ql_io_regs.sv
`timescale 1ns/1ps

module ql_io_regs
(
	input  logic                 clk_sys,
	input  logic                 core_reset,
	input  ql_bus_pkg::cpu_bus_t cpu_bus,
	input  logic [23:0]          addr,
	input  ql_bus_pkg::region_t  region,
	output logic                 rom_shadow,
	output logic [7:0]           mc_stat
);
	import ql_bus_pkg::*;

	logic gc_wr_hi; // Upper byte only write into GoldCard I/O
	logic mc_wr;

	assign gc_wr_hi = region.gc_io && region.wr && cpu_bus.uds && !cpu_bus.lds;
	assign mc_wr    = region.wr && cpu_bus.lds && (addr == MC_STAT_ADDR);

	// GoldCard shadow RAM enable
	always_ff @(posedge clk_sys)
	begin
		if (core_reset)
			rom_shadow <= 1'b0;
		else if (gc_wr_hi && addr[7:0] == GC_SHADOW_ON)
			rom_shadow <= 1'b1; // OS ROM reads come from SDRAM
		else if (gc_wr_hi && addr[7:0] == GC_SHADOW_OFF)
			rom_shadow <= 1'b0;
	end

	// ZX8301 write-only mode register
	always_ff @(posedge clk_sys)
	begin
		if (core_reset)
			mc_stat <= 8'h00;
		else if (mc_wr)
			mc_stat <= cpu_bus.dout[7:0]; // Odd byte lane
	end

endmodule

// File: rtl/ql_data_mux.sv
`timescale 1ns/1ps

module ql_data_mux
(
	input  ql_bus_pkg::cpu_bus_t cpu_bus,
	input  logic [23:0]          addr,
	input  ql_bus_pkg::region_t  region,
	input  logic                 rom_shadow,
	input  ql_bus_pkg::ram_cfg_e eff_ram_cfg,
	input  logic [15:0]          ql_rom_dout,
	input  logic [15:0]          gc_rom_dout,
	input  logic [15:0]          sdram_dout,
	input  logic                 sdram_dtack,
	input  logic [15:0]          io_dout,
	output logic [15:0]          cpu_din,
	output logic                 cpu_dtack,
	output logic [22:0]          sdram_addr,
	output logic                 sdram_wr,
	output logic                 sdram_oe
);
	import ql_bus_pkg::*;

	logic gc_en;
	logic shadow_rd; // OS ROM read served by shadow RAM
	logic shadow_wr; // OS ROM write fills shadow RAM

	assign gc_en     = (eff_ram_cfg == RAM_4096K);
	assign shadow_rd = region.rd && region.os_rom && rom_shadow;
	assign shadow_wr = region.wr && region.os_rom && !rom_shadow;

	// Read data, I/O first, then the active memory map
	always_comb
	begin
		cpu_din = UNMAPPED_DATA;
		if (region.ql_io)
			cpu_din = io_dout;
		else if (!gc_en)
		begin
			if (region.rom)
				cpu_din = ql_rom_dout;
			else if (region.ram)
				cpu_din = sdram_dout;
		end
		else if (!rom_shadow)
		begin
			if (region.rom || region.gc_boot_rom)
				cpu_din = gc_rom_dout; // GoldCard boot
			else if (region.gc_os_rom || !region.ram)
				cpu_din = region.gc_os_rom ? ql_rom_dout : UNMAPPED_DATA;
			else
				cpu_din = sdram_dout;
		end
		else if (region.os_rom || region.ram)
			cpu_din = sdram_dout; // Shadow copy of OS ROM
		else if (region.ext_rom || region.gc_os_rom)
			cpu_din = ql_rom_dout;
	end

	assign sdram_addr = addr[23:1]; // Word address
	assign sdram_oe   = (region.rd && region.ram) || shadow_rd;
	assign sdram_wr   = (region.wr && region.ram) || shadow_wr;

	// Only SDRAM cycles wait, everything else acks at once
	assign cpu_dtack = (region.ram || shadow_rd || shadow_wr) ? sdram_dtack : cpu_bus.as;

endmodule

// File: rtl/ql_bus_top.sv
`timescale 1ns/1ps

module ql_bus_top
#(
	parameter int RESET_TICKS = 4095
)
(
	input  logic                 clk_sys,
	input  logic                 reset,
	// APB configuration port
	input  logic [7:0]           paddr,
	input  logic                 psel,
	input  logic                 penable,
	input  logic                 pwrite,
	input  logic [31:0]          pwdata,
	output logic [31:0]          prdata,
	output logic                 pready,
	output logic                 pslverr,
	// CPU side
	input  ql_bus_pkg::cpu_bus_t cpu_bus,
	output logic [15:0]          cpu_din,
	output logic                 cpu_dtack,
	// Memory and peripheral data
	input  logic [15:0]          ql_rom_dout,
	input  logic [15:0]          gc_rom_dout,
	input  logic [15:0]          sdram_dout,
	input  logic                 sdram_dtack,
	input  logic [15:0]          io_dout,
	output logic [22:0]          sdram_addr,
	output logic                 sdram_wr,
	output logic                 sdram_oe,
	// Clock enables and status
	output logic                 ce_bus_p,
	output logic                 ce_bus_n,
	output logic                 ce_sd,
	output logic                 ce_11m,
	output logic                 core_reset,
	output logic [7:0]           mc_stat
);
	import ql_bus_pkg::*;

	cpu_speed_e  cpu_speed;
	ram_cfg_e    eff_ram_cfg;
	logic [23:0] addr;       // Masked CPU address
	region_t     region;
	logic        rom_shadow;

	ql_cfg_apb #(.RESET_TICKS(RESET_TICKS)) ql_cfg_apb_inst
	(
		.clk_sys     (clk_sys),
		.reset       (reset),
		.paddr       (paddr),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.ce_bus_p    (ce_bus_p),
		.rom_shadow  (rom_shadow),
		.mc_stat     (mc_stat),
		.cpu_speed   (cpu_speed),
		.eff_ram_cfg (eff_ram_cfg),
		.core_reset  (core_reset)
	);

	ql_ce_gen ql_ce_gen_inst
	(
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cpu_speed (cpu_speed),
		.ce_bus_p  (ce_bus_p),
		.ce_bus_n  (ce_bus_n),
		.ce_sd     (ce_sd),
		.ce_11m    (ce_11m)
	);

	ql_addr_decode ql_addr_decode_inst
	(
		.cpu_bus     (cpu_bus),
		.eff_ram_cfg (eff_ram_cfg),
		.addr        (addr),
		.region      (region)
	);

	ql_io_regs ql_io_regs_inst
	(
		.clk_sys    (clk_sys),
		.core_reset (core_reset),
		.cpu_bus    (cpu_bus),
		.addr       (addr),
		.region     (region),
		.rom_shadow (rom_shadow),
		.mc_stat    (mc_stat)
	);

	ql_data_mux ql_data_mux_inst
	(
		.cpu_bus     (cpu_bus),
		.addr        (addr),
		.region      (region),
		.rom_shadow  (rom_shadow),
		.eff_ram_cfg (eff_ram_cfg),
		.ql_rom_dout (ql_rom_dout),
		.gc_rom_dout (gc_rom_dout),
		.sdram_dout  (sdram_dout),
		.sdram_dtack (sdram_dtack),
		.io_dout     (io_dout),
		.cpu_din     (cpu_din),
		.cpu_dtack   (cpu_dtack),
		.sdram_addr  (sdram_addr),
		.sdram_wr    (sdram_wr),
		.sdram_oe    (sdram_oe)
	);

endmodule

// File: verification/ql_bus_tb.sv
`timescale 1ns/1ps

module ql_bus_tb;
	import ql_bus_pkg::*;

	localparam int TICKS  = 8;    // Short reset stretch
	localparam int LIMIT  = 2000; // Cycles before a wait gives up
	localparam int CE_WIN = 4000; // Clock-enable count window

	typedef enum logic [1:0] {SH_NONE, SH_ON, SH_OFF} shadow_op_e;
	typedef enum logic [2:0] {SRC_QLROM, SRC_GCROM, SRC_SDRAM, SRC_IO, SRC_NONE, SRC_X} src_e;

	// One table row: config, shadow action, bus op and what should come back
	typedef struct packed {
		ram_cfg_e    cfg;
		shadow_op_e  shadow;
		logic        rd;       // 1 = read, 0 = word write
		logic [23:0] addr;
		src_e        src;      // Expected cpu_din source on reads
		logic        sd;       // Expected sdram_oe (read) or sdram_wr (write)
		logic        dt_sdram; // DTACK follows sdram_dtack
	} row_t;

	localparam int NROWS = 24;

	row_t rows [0:NROWS-1] = '{
		'{RAM_128K,  SH_NONE, 1'b1, 24'h000100, SRC_QLROM, 1'b0, 1'b0},
		'{RAM_128K,  SH_NONE, 1'b1, 24'h028000, SRC_SDRAM, 1'b1, 1'b1},
		'{RAM_128K,  SH_NONE, 1'b1, 24'h018000, SRC_IO,    1'b0, 1'b0},
		'{RAM_128K,  SH_NONE, 1'b1, 24'h040000, SRC_QLROM, 1'b0, 1'b0}, // Wraps to 0
		'{RAM_128K,  SH_NONE, 1'b1, 24'h07FFFE, SRC_SDRAM, 1'b1, 1'b1},
		'{RAM_128K,  SH_NONE, 1'b1, 24'h010000, SRC_NONE,  1'b0, 1'b0},
		'{RAM_640K,  SH_NONE, 1'b1, 24'h0A0000, SRC_SDRAM, 1'b1, 1'b1},
		'{RAM_640K,  SH_NONE, 1'b1, 24'h0C0000, SRC_NONE,  1'b0, 1'b0},
		'{RAM_640K,  SH_NONE, 1'b1, 24'h1A0000, SRC_SDRAM, 1'b1, 1'b1}, // 1M wrap
		'{RAM_896K,  SH_NONE, 1'b1, 24'h0F0000, SRC_SDRAM, 1'b1, 1'b1},
		'{RAM_896K,  SH_NONE, 1'b1, 24'h00C000, SRC_QLROM, 1'b0, 1'b0},
		'{RAM_896K,  SH_NONE, 1'b0, 24'h030000, SRC_X,     1'b1, 1'b1},
		'{RAM_896K,  SH_NONE, 1'b0, 24'h001000, SRC_X,     1'b1, 1'b1}, // OS ROM write
		'{RAM_4096K, SH_NONE, 1'b1, 24'h000100, SRC_GCROM, 1'b0, 1'b0},
		'{RAM_4096K, SH_NONE, 1'b1, 24'h040100, SRC_GCROM, 1'b1, 1'b1}, // Boot copy over xram
		'{RAM_4096K, SH_NONE, 1'b1, 24'h400100, SRC_QLROM, 1'b0, 1'b0},
		'{RAM_4096K, SH_NONE, 1'b1, 24'h010000, SRC_SDRAM, 1'b1, 1'b1},
		'{RAM_4096K, SH_NONE, 1'b1, 24'h01C200, SRC_SDRAM, 1'b1, 1'b1},
		'{RAM_4096K, SH_NONE, 1'b1, 24'h01C000, SRC_NONE,  1'b0, 1'b0},
		'{RAM_4096K, SH_ON,   1'b1, 24'h000100, SRC_SDRAM, 1'b1, 1'b1}, // Shadow read
		'{RAM_4096K, SH_NONE, 1'b1, 24'h00C100, SRC_QLROM, 1'b0, 1'b0},
		'{RAM_4096K, SH_NONE, 1'b0, 24'h000100, SRC_X,     1'b0, 1'b0},
		'{RAM_4096K, SH_OFF,  1'b1, 24'h800100, SRC_GCROM, 1'b0, 1'b0}, // 8M wrap
		'{RAM_4096K, SH_NONE, 1'b0, 24'h000100, SRC_X,     1'b1, 1'b1}
	};

	logic        clk_sys;
	logic        reset;
	logic [7:0]  paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	cpu_bus_t    cpu_bus;
	logic [15:0] cpu_din;
	logic        cpu_dtack;
	logic [15:0] ql_rom_dout;
	logic [15:0] gc_rom_dout;
	logic [15:0] sdram_dout;
	logic        sdram_dtack;
	logic [15:0] io_dout;
	logic [22:0] sdram_addr;
	logic        sdram_wr;
	logic        sdram_oe;
	logic        ce_bus_p;
	logic        ce_bus_n;
	logic        ce_sd;
	logic        ce_11m;
	logic        core_reset;
	logic [7:0]  mc_stat;

	int          errors;
	logic [15:0] lfsr_state;
	ram_cfg_e    cur_cfg;
	cpu_speed_e  cur_speed;
	logic        exp_shadow; // Shadow state the testbench expects

	ql_bus_top #(.RESET_TICKS(TICKS)) ql_bus_top_inst
	(
		.clk_sys     (clk_sys),
		.reset       (reset),
		.paddr       (paddr),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.cpu_bus     (cpu_bus),
		.cpu_din     (cpu_din),
		.cpu_dtack   (cpu_dtack),
		.ql_rom_dout (ql_rom_dout),
		.gc_rom_dout (gc_rom_dout),
		.sdram_dout  (sdram_dout),
		.sdram_dtack (sdram_dtack),
		.io_dout     (io_dout),
		.sdram_addr  (sdram_addr),
		.sdram_wr    (sdram_wr),
		.sdram_oe    (sdram_oe),
		.ce_bus_p    (ce_bus_p),
		.ce_bus_n    (ce_bus_n),
		.ce_sd       (ce_sd),
		.ce_11m      (ce_11m),
		.core_reset  (core_reset),
		.mc_stat     (mc_stat)
	);

	initial
	begin
		clk_sys = 1'b0;
		forever #20 clk_sys = !clk_sys; // 25 MHz sim clock
	end

	// Fibonacci LFSR x^16+x^14+x^13+x^11, one step per bit taken
	function automatic logic [15:0] lfsr_bits(input int n);
		logic [15:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			r = {r[14:0], fb};
		end
		return r;
	endfunction

	function automatic logic [23:0] addr_mask(input ram_cfg_e c);
		case (c)
			RAM_128K:           return 24'h03FFFF;
			RAM_640K, RAM_896K: return 24'h0FFFFF;
			default:            return 24'h7FFFFF;
		endcase
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	// Pulse count within one of the ideal rate
	task automatic compare_rate(input string name, input int got, input real exp);
		assert ((got - exp <= 1.0) && (exp - got <= 1.0))
		else
		begin
			$display("MISMATCH %s: got %h expected ~%h", name, got, int'(exp));
			errors++;
		end
	endtask

	//==========================================================================
	// APB and CPU bus drivers
	//==========================================================================
	task automatic apb_xfer(input logic [7:0] a, input logic w, input logic [31:0] wd,
		input logic exp_err, output logic [31:0] rd);
		@(posedge clk_sys);
		#2;
		paddr   = a; // Setup phase
		pwrite  = w;
		pwdata  = wd;
		psel    = 1'b1;
		penable = 1'b0;
		@(posedge clk_sys);
		#2;
		penable = 1'b1;
		@(negedge clk_sys);
		rd = prdata;
		check_val("pslverr", pslverr, exp_err);
		check_val("pready", pready, 1'b1);
		@(posedge clk_sys); // Write lands here
		#2;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic cpu_write(input logic [23:0] a, input logic u, input logic l,
		input logic [15:0] d);
		@(posedge clk_sys);
		#2;
		cpu_bus = '{addr: a, as: 1'b1, rw: 1'b0, uds: u, lds: l, dout: d};
		@(posedge clk_sys);
		#2;
		cpu_bus = '0;
	endtask

	// Count ce_bus_p pulses until core_reset drops
	task automatic count_stretch();
		int  cnt;
		int  timer;
		logic done;
		cnt   = 0;
		timer = 0;
		done  = 1'b0;
		while (!done)
		begin
			@(negedge clk_sys);
			if (!core_reset)
				done = 1'b1;
			else if (ce_bus_p)
				cnt++;
			timer++;
			if (!done && timer > LIMIT)
			begin
				$display("Timeout: core_reset never fell");
				errors++;
				done = 1'b1;
			end
		end
		check_val("reset_ticks", cnt, TICKS);
	endtask

	// Soft reset with a new RAM size, then confirm it was latched
	task automatic configure(input ram_cfg_e c);
		logic [31:0] d;
		apb_xfer(REG_CTRL, 1'b1, {27'd0, 1'b1, c, cur_speed}, 1'b0, d);
		apb_xfer(REG_CTRL, 1'b1, {27'd0, 1'b0, c, cur_speed}, 1'b0, d);
		count_stretch();
		cur_cfg    = c;
		exp_shadow = 1'b0; // Core reset clears the shadow
		apb_xfer(REG_STATUS, 1'b0, 32'd0, 1'b0, d);
		check_val("eff_ram_cfg", d[1:0], c);
		check_val("rom_shadow", d[2], 1'b0);
	endtask

	task automatic apply_row(input row_t r);
		logic [31:0] d;
		logic [15:0] exp_din;
		if (r.cfg != cur_cfg)
			configure(r.cfg);
		if (r.shadow != SH_NONE)
		begin
			cpu_write({16'h01C0, (r.shadow == SH_ON) ? 8'h60 : 8'h64}, 1'b1, 1'b0, 16'h0);
			exp_shadow = (r.shadow == SH_ON);
			apb_xfer(REG_STATUS, 1'b0, 32'd0, 1'b0, d);
			check_val("rom_shadow", d[2], exp_shadow);
		end
		@(posedge clk_sys);
		#2;
		// Fixed top nibbles keep the four sources apart
		ql_rom_dout = 16'h1000 | lfsr_bits(12);
		gc_rom_dout = 16'h2000 | lfsr_bits(12);
		sdram_dout  = 16'h3000 | lfsr_bits(12);
		io_dout     = 16'h4000 | lfsr_bits(12);
		sdram_dtack = (lfsr_bits(1) != 16'd0);
		cpu_bus = '{addr: r.addr, as: 1'b1, rw: r.rd, uds: 1'b1, lds: 1'b1,
			dout: lfsr_bits(16)};
		case (r.src)
			SRC_QLROM: exp_din = ql_rom_dout;
			SRC_GCROM: exp_din = gc_rom_dout;
			SRC_SDRAM: exp_din = sdram_dout;
			SRC_IO:    exp_din = io_dout;
			default:   exp_din = 16'hFFFF;
		endcase
		@(negedge clk_sys);
		if (r.rd)
		begin
			check_val("cpu_din", cpu_din, exp_din);
			check_val("sdram_oe", sdram_oe, r.sd);
			check_val("sdram_wr", sdram_wr, 1'b0);
		end
		else
		begin
			check_val("sdram_wr", sdram_wr, r.sd);
			check_val("sdram_oe", sdram_oe, 1'b0);
		end
		check_val("cpu_dtack", cpu_dtack, r.dt_sdram ? sdram_dtack : 1'b1);
		check_val("sdram_addr", sdram_addr, (r.addr & addr_mask(r.cfg)) >> 1);
		@(posedge clk_sys);
		#2;
		cpu_bus = '0;
	endtask

	// Pulse counts for one speed against the accumulator rule
	task automatic check_ce(input cpu_speed_e s, input logic [16:0] inc);
		logic [31:0] d;
		int          np;
		int          nn;
		int          nsd;
		int          n11;
		real         e;
		cur_speed = s;
		apb_xfer(REG_CTRL, 1'b1, {27'd0, 1'b0, cur_cfg, s}, 1'b0, d);
		np  = 0;
		nn  = 0;
		nsd = 0;
		n11 = 0;
		for (int i = 0; i < CE_WIN; i++)
		begin
			@(negedge clk_sys);
			np  += ce_bus_p;
			nn  += ce_bus_n;
			nsd += ce_sd;
			n11 += ce_11m;
			assert (!(ce_bus_p && ce_bus_n))
			else
			begin
				$display("ce_bus_p and ce_bus_n high in the same cycle");
				errors++;
			end
		end
		e = CE_WIN * real'(inc) / 65536.0;
		compare_rate("ce_bus_p", np, e / 2.0);
		compare_rate("ce_bus_n", nn, e / 2.0);
		compare_rate("ce_sd", nsd, CE_WIN * 19505.0 / 65536.0);
		compare_rate("ce_11m", n11, CE_WIN * 8582.0 / 65536.0);
	endtask

	//==========================================================================
	// Main sequence
	//==========================================================================
	initial
	begin
		logic [31:0] d;
		errors      = 0;
		lfsr_state  = 16'd19306;
		cur_cfg     = RAM_128K;
		cur_speed   = SPEED_QL;
		exp_shadow  = 1'b0;
		reset       = 1'b1;
		paddr       = '0;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		pwdata      = '0;
		cpu_bus     = '0;
		ql_rom_dout = '0;
		gc_rom_dout = '0;
		sdram_dout  = '0;
		sdram_dtack = 1'b0;
		io_dout     = '0;
		repeat (16) @(posedge clk_sys);
		#2;
		reset = 1'b0;
		count_stretch();

		// Register readback and bad offsets
		apb_xfer(REG_CTRL, 1'b1, 32'h0000_0009, 1'b0, d); // RAM_896K request, SPEED_16
		apb_xfer(REG_CTRL, 1'b0, 32'd0, 1'b0, d);
		check_val("prdata", d, 32'h0000_0009);
		apb_xfer(8'h08, 1'b1, 32'h0000_001F, 1'b1, d);
		apb_xfer(8'h08, 1'b0, 32'd0, 1'b1, d);
		check_val("prdata", d, 32'd0);
		apb_xfer(REG_CTRL, 1'b0, 32'd0, 1'b0, d);
		check_val("prdata", d, 32'h0000_0009);
		apb_xfer(REG_STATUS, 1'b0, 32'd0, 1'b0, d);
		check_val("eff_ram_cfg", d[1:0], RAM_128K); // Not latched outside reset
		apb_xfer(REG_CTRL, 1'b1, {27'd0, 1'b0, RAM_128K, SPEED_QL}, 1'b0, d);

		for (int i = 0; i < NROWS; i++)
			apply_row(rows[i]);

		// ZX8301 mode register
		cpu_write(MC_STAT_ADDR, 1'b0, 1'b1, 16'h00A5);
		check_val("mc_stat", mc_stat, 8'hA5);
		cpu_write(24'h018062, 1'b0, 1'b1, 16'h005A);
		cpu_write(24'h018064, 1'b0, 1'b1, 16'h005A);
		check_val("mc_stat", mc_stat, 8'hA5);
		apb_xfer(REG_STATUS, 1'b0, 32'd0, 1'b0, d);
		check_val("status_mc_stat", d[15:8], 8'hA5);

		check_ce(SPEED_QL,   FRACT_BUS_QL);
		check_ce(SPEED_16,   FRACT_BUS_16);
		check_ce(SPEED_24,   FRACT_BUS_24);
		check_ce(SPEED_FULL, FRACT_BUS_FULL);

		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: flist.f
rtl/ql_bus_pkg.sv
rtl/ql_cfg_apb.sv
rtl/ql_ce_gen.sv
rtl/ql_addr_decode.sv
rtl/ql_io_regs.sv
rtl/ql_data_mux.sv
rtl/ql_bus_top.sv
verification/ql_bus_tb.sv
